// ==== common/pcie_app_pkg.sv ====
/*
  Shared types and constants for the PCIe programmed-I/O endpoint.
  Holds the streaming beat, the receive word views and the request record
  passed from the decoder through the buffer to the completion engine.
*/
package pcie_app_pkg;

  // ------------------------------
  // Widths and TLP codes
  // ------------------------------
  localparam int DATA_W = 64;                     // Streaming beat width
  localparam int KEEP_W = DATA_W / 8;             // One keep bit per byte
  localparam int ADDR_W = 8;                      // Word address, sized for 256 words

  localparam logic [6:0] FMT_MRD32 = 7'b000_0000; // 3DW header, no data
  localparam logic [6:0] FMT_MWR32 = 7'b100_0000; // 3DW header, with data
  localparam logic [6:0] FMT_CPLD  = 7'b100_1010; // Completion with data

  localparam logic [2:0] CPL_STATUS_SC = 3'b000;  // Successful completion

  // One beat of the streaming bus, used on both directions
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [KEEP_W-1:0] keep;
    logic              last;
    logic              valid;
  } stream_beat_t;

  // First receive beat, DW1 in the upper half
  typedef struct packed {
    logic [15:0] requester_id;
    logic [7:0]  tag;
    logic [3:0]  last_be;
    logic [3:0]  first_be;
    logic        rsvd0;
    logic [6:0]  fmt_type;                        // Format and type together
    logic        rsvd1;
    logic [2:0]  tc;
    logic [5:0]  rsvd2;                           // TH, TD, EP and friends
    logic [1:0]  attr;
    logic [1:0]  at;
    logic [9:0]  length;                          // In dwords
  } rx_hdr_t;

  // Second receive beat, address dword first
  typedef struct packed {
    logic [31:0] payload;                         // Write data, don't care on reads
    logic [31:0] address;                         // Bits 1:0 reserved
  } rx_adr_t;

  typedef union packed {
    rx_hdr_t hdr;
    rx_adr_t adr;
  } rx_word_u;

  // Decoded request
  typedef struct packed {
    logic              is_write;
    logic [15:0]       requester_id;
    logic [7:0]        tag;
    logic [3:0]        first_be;
    logic [ADDR_W-1:0] addr;
    logic [31:0]       wdata;
  } pio_req_t;

  typedef struct packed {
    logic [7:0] bus;
    logic [4:0] device;
    logic [2:0] func;
  } completer_id_t;

endpackage

// ==== rx_engine/pcie_rx_engine.sv ====
/*
  Receive decoder. Splits two-beat MRd32/MWr32 TLPs into pio requests,
  drops anything else up to its last beat. Holds the credit count for
  the request buffer and stalls new TLPs while no credit is left.
*/
module pcie_rx_engine import pcie_app_pkg::*; #(
  parameter int REQ_DEPTH = 4
) (
  input  logic         w_pcie_user_clk,
  input  logic         i_rst_n,
  input  stream_beat_t i_rx,
  output logic         o_rx_ready,
  output logic         o_push,
  output pio_req_t     o_req,
  input  logic         i_credit_return
);

  localparam int CNT_W = $clog2(REQ_DEPTH + 1);

  typedef enum logic [1:0] {
    ST_HDR,                                       // Waiting for header beat
    ST_ADDR,                                      // Waiting for address/data beat
    ST_DISCARD                                    // Swallowing an unsupported TLP
  } rx_state_e;

  rx_state_e        r_state;
  logic [CNT_W-1:0] r_credit;
  logic             r_loaded;                     // Credits loaded after reset
  logic             r_push;
  pio_req_t         r_req;
  rx_word_u         w_word;
  logic             w_fire;
  logic             w_hdr_ok;
  logic             w_spend;

  assign w_word = i_rx.data;
  assign w_fire = i_rx.valid && o_rx_ready;

  // Single dword, 32-bit address, two beats
  assign w_hdr_ok = (w_word.hdr.fmt_type == FMT_MRD32 || w_word.hdr.fmt_type == FMT_MWR32) &&
                    (w_word.hdr.length == 10'd1) && !i_rx.last;

  // Credit is taken when the second beat lands
  assign w_spend = w_fire && (r_state == ST_ADDR) && i_rx.last;

  // New TLP only with a free slot
  assign o_rx_ready = (r_state == ST_HDR) ? (r_credit != '0) : 1'b1;

  assign o_push = r_push;
  assign o_req  = r_req;

  // ------------------------------
  // Beat FSM
  // ------------------------------
  always_ff @(posedge w_pcie_user_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_state <= ST_HDR;
      r_push  <= 1'b0;
    end else begin
      r_push <= w_spend;                          // Push one cycle after beat two
      if (w_fire) begin
        case (r_state)
          ST_HDR:     if (w_hdr_ok) r_state <= ST_ADDR;
                      else if (!i_rx.last) r_state <= ST_DISCARD;
          ST_ADDR:    r_state <= i_rx.last ? ST_HDR : ST_DISCARD;
          ST_DISCARD: if (i_rx.last) r_state <= ST_HDR;
          default:    r_state <= ST_HDR;
        endcase
      end
    end
  end

  // ------------------------------
  // Credit counter
  // ------------------------------
  always_ff @(posedge w_pcie_user_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_credit <= '0;
      r_loaded <= 1'b0;
    end else if (!r_loaded) begin
      r_credit <= REQ_DEPTH[CNT_W-1:0];           // Buffer starts empty
      r_loaded <= 1'b1;
    end else begin
      r_credit <= r_credit + CNT_W'(i_credit_return) - CNT_W'(w_spend);
    end
  end

  // Request fields, filled beat by beat
  always_ff @(posedge w_pcie_user_clk) begin
    if (w_fire && r_state == ST_HDR) begin
      r_req.is_write     <= (w_word.hdr.fmt_type == FMT_MWR32);
      r_req.requester_id <= w_word.hdr.requester_id;
      r_req.tag          <= w_word.hdr.tag;
      r_req.first_be     <= w_word.hdr.first_be;
    end
    if (w_fire && r_state == ST_ADDR) begin
      r_req.addr  <= w_word.adr.address[ADDR_W+1:2]; // Byte to word address
      r_req.wdata <= w_word.adr.payload;
    end
  end

endmodule

// ==== sim/pcie_app_assertions.sv ====
/*
  Protocol assertions for the PCIe PIO endpoint.
  Bound into the top level, watches the streaming ports and turn-off.
*/
module pcie_app_assertions import pcie_app_pkg::*; (
  input logic         w_pcie_user_clk,
  input logic         i_rst_n,
  input logic         o_rx_ready,
  input stream_beat_t o_tx,
  input logic         i_tx_ready,
  input logic         i_cfg_to_turnoff,
  input logic         o_cfg_turnoff_ok
);
  timeunit 1ns;
  timeprecision 100ps;

  // Stalled completion beat must not move
  a_tx_hold: assert property (@(posedge w_pcie_user_clk) disable iff (!i_rst_n)
    o_tx.valid && !i_tx_ready |=> o_tx.valid && $stable(o_tx.data) && $stable(o_tx.last))
    else $error("o_tx changed while i_tx_ready was low");

  // Both handshakes quiet in reset
  a_reset_quiet: assert property (@(posedge w_pcie_user_clk)
    !i_rst_n |-> !o_rx_ready && !o_tx.valid)
    else $error("o_rx_ready or o_tx.valid high during reset");

  a_turnoff_req: assert property (@(posedge w_pcie_user_clk) disable iff (!i_rst_n)
    o_cfg_turnoff_ok |-> i_cfg_to_turnoff)    // Answer only to a request
    else $error("o_cfg_turnoff_ok high without i_cfg_to_turnoff");

endmodule

bind pcie_app_top pcie_app_assertions u_pcie_app_assertions (.*);

// ==== sim/pcie_app_tb.sv ====
/*
  Testbench for the PCIe PIO endpoint. Sends random MRd32, MWr32 and
  unsupported TLPs, keeps a memory model and checks every completion beat.
  Covers back-pressure, the credit stall and the turn-off answer.
*/
module pcie_app_tb import pcie_app_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 8;
  localparam int RST_CYCLES = 16;
  localparam int NUM_RAND   = 150;
  localparam int NUM_TXN    = 16 + 9 + NUM_RAND + 9;   // Preload, directed, random, burst+turn-off
  localparam int TIMEOUT_NS = RST_CYCLES * CLK_PERIOD + NUM_TXN * 200;

  typedef struct packed {
    logic [15:0] rid;
    logic [7:0]  tag;
    logic [7:0]  addr;
    logic [31:0] data;
  } exp_cpl_t;

  logic          w_pcie_user_clk;
  logic          i_rst_n;
  stream_beat_t  i_rx;
  logic          o_rx_ready;
  stream_beat_t  o_tx;
  logic          i_tx_ready;
  completer_id_t i_completer_id;
  logic          i_cfg_to_turnoff;
  logic          o_cfg_turnoff_ok;

  logic [31:0]   model_mem [256];                    // Expected word contents
  logic [7:0]    pool [16];                          // Addresses in use
  exp_cpl_t      exp_q [$];                          // Reads waiting for a CplD
  exp_cpl_t      cur_exp;
  logic [31:0]   seed_stim;
  logic [31:0]   seed_rdy;
  logic [7:0]    tag_cnt = 8'd0;
  logic          hold_low = 1'b0;                    // Forces tready low
  logic          in_second = 1'b0;                   // Next CplD beat is the data beat
  int            n_errors = 0;
  int            n_checks = 0;
  int            n_reads = 0;
  int            n_cpl = 0;

  pcie_app_top u_pcie_app_top (
    .w_pcie_user_clk  (w_pcie_user_clk),
    .i_rst_n          (i_rst_n),
    .i_rx             (i_rx),
    .o_rx_ready       (o_rx_ready),
    .o_tx             (o_tx),
    .i_tx_ready       (i_tx_ready),
    .i_completer_id   (i_completer_id),
    .i_cfg_to_turnoff (i_cfg_to_turnoff),
    .o_cfg_turnoff_ok (o_cfg_turnoff_ok)
  );

  initial begin
    w_pcie_user_clk = 1'b0;
    forever #(CLK_PERIOD / 2) w_pcie_user_clk = ~w_pcie_user_clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // ------------------------------
  // Receive side driver
  // ------------------------------
  task automatic send_beat(input logic [63:0] data, input logic last);
    @(negedge w_pcie_user_clk);
    i_rx.data  = data;
    i_rx.keep  = '1;
    i_rx.last  = last;
    i_rx.valid = 1'b1;
    @(posedge w_pcie_user_clk);
    while (!o_rx_ready) @(posedge w_pcie_user_clk);  // Hold until accepted
  endtask

  task automatic clear_rx();
    @(negedge w_pcie_user_clk);
    i_rx.valid = 1'b0;
  endtask

  // Model update first, then the beats; requests run in order
  task automatic send_tlp(input logic [6:0] fmt, input logic [9:0] len, input logic [3:0] be,
                          input logic [7:0] addr, input logic [31:0] wdata);
    logic [15:0] rid;
    seed_stim = xorshift32(seed_stim);
    rid = seed_stim[15:0];
    if (fmt == FMT_MWR32 && len == 10'd1) begin
      for (int b = 0; b < 4; b++)
        if (be[b]) model_mem[addr][b*8 +: 8] = wdata[b*8 +: 8];
    end else if (fmt == FMT_MRD32 && len == 10'd1) begin
      exp_q.push_back('{rid, tag_cnt, addr, model_mem[addr]});
      n_reads++;
    end
    send_beat({rid, tag_cnt, 4'b0000, be, 1'b0, fmt, 1'b0, 3'b000, 6'b0, 4'b0, len}, 1'b0);
    send_beat({wdata, 22'b0, addr, 2'b00}, len == 10'd1);
    if (len != 10'd1) send_beat({seed_stim, ~seed_stim}, 1'b1); // Extra dword, discarded
    tag_cnt++;
    if (seed_stim[18:17] != 2'b00) clear_rx();      // Else next TLP goes back to back
  endtask

  task automatic drain();
    while (exp_q.size() != 0 || o_tx.valid) @(posedge w_pcie_user_clk);
  endtask

  task automatic wait_turnoff();
    logic seen;
    seen = 1'b0;
    repeat (30) begin
      @(posedge w_pcie_user_clk);
      if (o_cfg_turnoff_ok) seen = 1'b1;
    end
    check_val("o_cfg_turnoff_ok", seen, 1'b1);
  endtask

  // Tready pattern, about three quarters high
  initial begin
    seed_rdy = ~32'ha757;
    forever begin
      @(negedge w_pcie_user_clk);
      seed_rdy   = xorshift32(seed_rdy);
      i_tx_ready = hold_low ? 1'b0 : (seed_rdy[1:0] != 2'b00);
    end
  end

  // ------------------------------
  // Completion monitor
  // ------------------------------
  always @(posedge w_pcie_user_clk) begin
    if (i_rst_n && o_cfg_turnoff_ok && o_tx.valid) begin
      n_errors++;
      $display("Turn-off acknowledged at %0t while a completion is on the bus", $time);
    end
    if (i_rst_n && o_tx.valid && i_tx_ready) begin
      check_val("o_tx.keep", o_tx.keep, 8'hff);
      if (!in_second) begin
        if (exp_q.size() == 0) begin
          n_errors++;
          $display("Completion at %0t with no read outstanding", $time);
        end
        check_val("cpl fmt_type", o_tx.data[30:24], FMT_CPLD);
        check_val("cpl length", o_tx.data[9:0], 10'd1);
        check_val("cpl completer_id", o_tx.data[63:48], i_completer_id);
        check_val("cpl status", o_tx.data[47:45], CPL_STATUS_SC);
        check_val("cpl byte_count", o_tx.data[43:32], 12'd4);
        check_val("cpl beat1 last", o_tx.last, 1'b0);
        in_second = 1'b1;
      end else begin
        n_cpl++;                                     // Every data beat on the bus
        if (exp_q.size() != 0) begin
          cur_exp = exp_q.pop_front();
          check_val("cpl data", o_tx.data[63:32], cur_exp.data);
          check_val("cpl requester_id", o_tx.data[31:16], cur_exp.rid);
          check_val("cpl tag", o_tx.data[15:8], cur_exp.tag);
          check_val("cpl lower_addr", o_tx.data[6:0], 7'({cur_exp.addr, 2'b00}));
        end
        check_val("cpl beat2 last", o_tx.last, 1'b1);
        in_second = 1'b0;
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout after %0d ns, traffic did not finish", TIMEOUT_NS);
    $display("Simulation failed");
    $finish;
  end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    logic [31:0] r;
    logic [7:0]  addr;
    logic        saw_stall;
    i_rst_n          = 1'b0;
    i_rx             = '0;
    i_tx_ready       = 1'b0;
    i_completer_id   = '{bus: 8'h5a, device: 5'd3, func: 3'd2};
    i_cfg_to_turnoff = 1'b0;
    seed_stim        = 32'ha757;
    saw_stall        = 1'b0;
    for (int i = 0; i < 16; i++) pool[i] = 8'(i * 17 + 5); // Spread over the map
    repeat (RST_CYCLES) @(negedge w_pcie_user_clk);
    i_rst_n = 1'b1;

    for (int i = 0; i < 16; i++) begin              // Full-word preload
      seed_stim = xorshift32(seed_stim);
      send_tlp(FMT_MWR32, 10'd1, 4'hf, pool[i], seed_stim);
    end
    send_tlp(FMT_MWR32, 10'd1, 4'hf, pool[0], 32'hcafe_f00d);
    send_tlp(FMT_MRD32, 10'd1, 4'hf, pool[0], 32'h0);
    send_tlp(FMT_MWR32, 10'd1, 4'b0101, pool[1], 32'h1122_3344); // Byte merges
    send_tlp(FMT_MRD32, 10'd1, 4'hf, pool[1], 32'h0);
    send_tlp(FMT_MWR32, 10'd1, 4'b1000, pool[1], 32'haabb_ccdd);
    send_tlp(FMT_MRD32, 10'd1, 4'hf, pool[1], 32'h0);
    send_tlp(7'b010_0000, 10'd1, 4'hf, pool[2], 32'h0);      // MRd64, dropped
    send_tlp(FMT_MWR32, 10'd2, 4'hf, pool[2], 32'hdead_beef); // Two dwords, dropped
    send_tlp(FMT_MRD32, 10'd1, 4'hf, pool[2], 32'h0);

    for (int n = 0; n < NUM_RAND; n++) begin
      seed_stim = xorshift32(seed_stim);
      r = seed_stim;
      addr = pool[r[7:4]];
      if (r[2:0] == 3'd0)
        send_tlp(r[8] ? 7'b010_0000 : FMT_MWR32, r[8] ? 10'd1 : 10'd2, 4'hf, addr, r);
      else if (r[2:0] < 3'd4)
        send_tlp(FMT_MWR32, 10'd1, (r[11:8] == 4'h0) ? 4'hf : r[11:8], addr,
                 {r[15:0], r[31:16]});
      else
        send_tlp(FMT_MRD32, 10'd1, 4'hf, addr, 32'h0);
    end
    clear_rx();
    drain();

    // Long tready stall, credits run out
    @(posedge w_pcie_user_clk);
    hold_low = 1'b1;
    fork
      begin
        for (int i = 0; i < 8; i++) send_tlp(FMT_MRD32, 10'd1, 4'hf, pool[i + 4], 32'h0);
        clear_rx();
      end
      begin
        repeat (80) begin
          @(posedge w_pcie_user_clk);
          if (i_rx.valid && !o_rx_ready) saw_stall = 1'b1;
        end
        hold_low = 1'b0;
      end
    join
    check_val("o_rx_ready stall seen", saw_stall, 1'b1);
    drain();

    // Turn-off once idle, and again after one more read
    @(negedge w_pcie_user_clk);
    i_cfg_to_turnoff = 1'b1;
    wait_turnoff();
    send_tlp(FMT_MRD32, 10'd1, 4'hf, pool[3], 32'h0);
    clear_rx();
    drain();
    wait_turnoff();
    @(negedge w_pcie_user_clk);
    i_cfg_to_turnoff = 1'b0;

    check_val("completion count", n_cpl, n_reads);
    $display("Done: %0d checks, %0d reads, %0d completions, %0d errors",
             n_checks, n_reads, n_cpl, n_errors);
    if (n_errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// ==== source/pcie_app_top.sv ====
/*
  Programmed-I/O endpoint behind the PCIe core user interface.
  Receive beats go to the decoder, requests wait in a credit buffer,
  the completion engine runs them against the register memory.
*/
module pcie_app_top import pcie_app_pkg::*; #(
  parameter int REQ_DEPTH = 4,                    // Request slots, also initial credits
  parameter int MEM_WORDS = 256                   // Register memory size
) (
  input  logic          w_pcie_user_clk,
  input  logic          i_rst_n,
  input  stream_beat_t  i_rx,
  output logic          o_rx_ready,
  output stream_beat_t  o_tx,
  input  logic          i_tx_ready,
  input  completer_id_t i_completer_id,
  input  logic          i_cfg_to_turnoff,
  output logic          o_cfg_turnoff_ok
);

  logic     w_push;                               // Decoder -> buffer
  pio_req_t w_req;
  logic     w_credit_return;                      // Buffer -> decoder
  pio_req_t w_head;                               // Buffer -> completion engine
  logic     w_head_valid;
  logic     w_pop;

  pcie_rx_engine #(.REQ_DEPTH(REQ_DEPTH)) u_rx_engine (
    .w_pcie_user_clk (w_pcie_user_clk),
    .i_rst_n         (i_rst_n),
    .i_rx            (i_rx),
    .o_rx_ready      (o_rx_ready),
    .o_push          (w_push),
    .o_req           (w_req),
    .i_credit_return (w_credit_return)
  );

  pcie_req_fifo #(.REQ_DEPTH(REQ_DEPTH)) u_req_fifo (
    .w_pcie_user_clk (w_pcie_user_clk),
    .i_rst_n         (i_rst_n),
    .i_push          (w_push),
    .i_req           (w_req),
    .o_head          (w_head),
    .o_head_valid    (w_head_valid),
    .i_pop           (w_pop),
    .o_credit_return (w_credit_return)
  );

  pcie_tx_engine #(.MEM_WORDS(MEM_WORDS)) u_tx_engine (
    .w_pcie_user_clk  (w_pcie_user_clk),
    .i_rst_n          (i_rst_n),
    .i_head           (w_head),
    .i_head_valid     (w_head_valid),
    .o_pop            (w_pop),
    .o_tx             (o_tx),
    .i_tx_ready       (i_tx_ready),
    .i_completer_id   (i_completer_id),
    .i_cfg_to_turnoff (i_cfg_to_turnoff),
    .o_cfg_turnoff_ok (o_cfg_turnoff_ok)
  );

endmodule

// ==== source/pcie_req_fifo.sv ====
/*
  Request buffer between decoder and completion engine.
  Circular store of pio requests; each pop hands one credit back.
*/
module pcie_req_fifo import pcie_app_pkg::*; #(
  parameter int REQ_DEPTH = 4
) (
  input  logic     w_pcie_user_clk,
  input  logic     i_rst_n,
  input  logic     i_push,
  input  pio_req_t i_req,
  output pio_req_t o_head,
  output logic     o_head_valid,
  input  logic     i_pop,
  output logic     o_credit_return
);

  localparam int PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
  localparam int CNT_W = $clog2(REQ_DEPTH + 1);

  pio_req_t         r_mem [REQ_DEPTH];
  logic [PTR_W-1:0] r_wr_ptr;
  logic [PTR_W-1:0] r_rd_ptr;
  logic [CNT_W-1:0] r_count;
  logic             r_credit;
  logic             w_pop;

  // Wrap at depth, not at a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign w_pop           = i_pop && o_head_valid;  // Pop on empty ignored
  assign o_head          = r_mem[r_rd_ptr];
  assign o_head_valid    = (r_count != '0);
  assign o_credit_return = r_credit;

  always_ff @(posedge w_pcie_user_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
      r_credit <= 1'b0;
    end else begin
      if (i_push) r_wr_ptr <= ptr_inc(r_wr_ptr); // Credits keep it from overflowing
      if (w_pop)  r_rd_ptr <= ptr_inc(r_rd_ptr);
      r_count  <= r_count + CNT_W'(i_push) - CNT_W'(w_pop);
      r_credit <= w_pop;                          // One strobe per freed slot
    end
  end

  always_ff @(posedge w_pcie_user_clk) begin
    if (i_push) r_mem[r_wr_ptr] <= i_req;
  end

endmodule

// ==== src.f ====
common/pcie_app_pkg.sv
tx_engine/pcie_pio_mem.sv
tx_engine/pcie_tx_engine.sv
source/pcie_req_fifo.sv
rx_engine/pcie_rx_engine.sv
source/pcie_app_top.sv
sim/pcie_app_assertions.sv
sim/pcie_app_tb.sv

// ==== tx_engine/pcie_pio_mem.sv ====
/*
  Register memory for the PIO endpoint. Byte-enabled writes,
  reads registered with one cycle of latency.
*/
module pcie_pio_mem #(
  parameter int MEM_WORDS = 256
) (
  input  logic                         w_pcie_user_clk,
  input  logic                         i_wr_en,
  input  logic                         i_rd_en,
  input  logic [$clog2(MEM_WORDS)-1:0] i_addr,
  input  logic [3:0]                   i_be,
  input  logic [31:0]                  i_wdata,
  output logic [31:0]                  o_rdata
);

  logic [31:0] r_mem [MEM_WORDS];                 // Undefined until written

  always_ff @(posedge w_pcie_user_clk) begin
    if (i_wr_en) begin
      for (int b = 0; b < 4; b++) begin
        if (i_be[b]) r_mem[i_addr][b*8 +: 8] <= i_wdata[b*8 +: 8]; // Enabled bytes only
      end
    end
    if (i_rd_en) o_rdata <= r_mem[i_addr];        // Holds until next read
  end

endmodule

// ==== tx_engine/pcie_tx_engine.sv ====
/*
  Completion engine. Pops requests in order, writes the register memory
  or reads it and sends a two-beat CplD. Beats are registered and hold
  under back-pressure. Also answers the turn-off request when idle.
*/
module pcie_tx_engine import pcie_app_pkg::*; #(
  parameter int MEM_WORDS = 256
) (
  input  logic          w_pcie_user_clk,
  input  logic          i_rst_n,
  input  pio_req_t      i_head,
  input  logic          i_head_valid,
  output logic          o_pop,
  output stream_beat_t  o_tx,
  input  logic          i_tx_ready,
  input  completer_id_t i_completer_id,
  input  logic          i_cfg_to_turnoff,
  output logic          o_cfg_turnoff_ok
);

  localparam int MEM_AW = $clog2(MEM_WORDS);      // Must not exceed ADDR_W

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WRITE,                                     // Memory write strobe
    ST_READ,                                      // Memory read strobe
    ST_CPL1,                                      // Header beat on the bus
    ST_CPL2                                       // Data beat on the bus
  } tx_state_e;

  tx_state_e         r_state;
  pio_req_t          r_req;
  logic [DATA_W-1:0] r_beat_data;
  logic              r_beat_last;
  logic              r_turnoff_ok;
  logic [31:0]       w_rdata;
  logic [DATA_W-1:0] w_beat1;
  logic [DATA_W-1:0] w_beat2;
  logic              w_idle;

  assign o_pop = (r_state == ST_IDLE) && i_head_valid;

  // ------------------------------
  // Completion beats
  // ------------------------------
  // DW1 | DW0: completer, status, byte count | CplD, length 1
  assign w_beat1 = {i_completer_id, CPL_STATUS_SC, 1'b0, 12'd4,
                    1'b0, FMT_CPLD, 1'b0, 3'b000, 6'b0, 2'b00, 2'b00, 10'd1};
  // DW3 | DW2: read data | requester, tag, lower address
  assign w_beat2 = {w_rdata, r_req.requester_id, r_req.tag, 1'b0, r_req.addr[4:0], 2'b00};

  always_comb begin
    o_tx.data  = r_beat_data;
    o_tx.keep  = '1;                              // Both dwords always present
    o_tx.last  = r_beat_last;
    o_tx.valid = (r_state == ST_CPL1) || (r_state == ST_CPL2);
  end

  always_ff @(posedge w_pcie_user_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_state <= ST_IDLE;
    end else begin
      case (r_state)
        ST_IDLE:  if (o_pop) r_state <= i_head.is_write ? ST_WRITE : ST_READ;
        ST_WRITE: r_state <= ST_IDLE;             // Posted, nothing to send
        ST_READ:  r_state <= ST_CPL1;
        ST_CPL1:  if (i_tx_ready) r_state <= ST_CPL2;
        ST_CPL2:  if (i_tx_ready) r_state <= ST_IDLE;
        default:  r_state <= ST_IDLE;
      endcase
    end
  end

  // Request copy and beat payload
  always_ff @(posedge w_pcie_user_clk) begin
    if (o_pop) r_req <= i_head;
    if (r_state == ST_READ) begin
      r_beat_data <= w_beat1;
      r_beat_last <= 1'b0;
    end else if (r_state == ST_CPL1 && i_tx_ready) begin
      r_beat_data <= w_beat2;                     // Read data settled by now
      r_beat_last <= 1'b1;
    end
  end

  // ------------------------------
  // Turn-off answer
  // ------------------------------
  assign w_idle = (r_state == ST_IDLE) && !i_head_valid;

  always_ff @(posedge w_pcie_user_clk or negedge i_rst_n) begin
    if (!i_rst_n) r_turnoff_ok <= 1'b0;
    else          r_turnoff_ok <= i_cfg_to_turnoff && w_idle;
  end

  // Drops at once when work shows up or the request goes away
  assign o_cfg_turnoff_ok = r_turnoff_ok && i_cfg_to_turnoff && w_idle;

  pcie_pio_mem #(.MEM_WORDS(MEM_WORDS)) u_pio_mem (
    .w_pcie_user_clk (w_pcie_user_clk),
    .i_wr_en         (r_state == ST_WRITE),
    .i_rd_en         (r_state == ST_READ),
    .i_addr          (r_req.addr[MEM_AW-1:0]),
    .i_be            (r_req.first_be),
    .i_wdata         (r_req.wdata),
    .o_rdata         (w_rdata)
  );

endmodule
